/* hdl/execPkg.sv */
package execPkg;

	// ======================================================================
	// datapath and register file sizes
	// ======================================================================

	localparam int DataWidth = 16;
	localparam int RegCount = 16;
	localparam int RegIdWidth = $clog2(RegCount);

	// ======================================================================
	// instruction encoding
	// ======================================================================

	localparam int OpWidth = 3;

	localparam logic [OpWidth-1:0] OpAdd = 3'd0;
	localparam logic [OpWidth-1:0] OpSub = 3'd1;
	localparam logic [OpWidth-1:0] OpAnd = 3'd2;
	localparam logic [OpWidth-1:0] OpOr = 3'd3;
	localparam logic [OpWidth-1:0] OpXor = 3'd4;
	localparam logic [OpWidth-1:0] OpLdi = 3'd5; // result is the immediate.
	localparam logic [OpWidth-1:0] OpMul = 3'd6; // low half of the product.
	// code 7 is left undefined and yields zero.

	// ======================================================================
	// multiplier
	// ======================================================================

	// one step per multiplier bit.
	localparam int MulSteps = DataWidth;
	localparam int StepWidth = $clog2(MulSteps);

endpackage

/* hdl/regFile.sv */
module regFile (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [execPkg::RegIdWidth-1:0] readId1,
	input  logic [execPkg::RegIdWidth-1:0] readId2,
	input  logic [execPkg::RegIdWidth-1:0] writeId,
	input  logic                          writeEnable,
	input  logic [execPkg::DataWidth-1:0]  writeData,
	output logic [execPkg::DataWidth-1:0]  readData1,
	output logic [execPkg::DataWidth-1:0]  readData2
);
	import execPkg::*;

	logic [DataWidth-1:0] regs [RegCount];
	logic bypass1;
	logic bypass2;

	// write port.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeId] <= writeData;
		end
	end

	// a read of the register being written sees the new value.
	assign bypass1 = writeEnable && (readId1 == writeId);
	assign bypass2 = writeEnable && (readId2 == writeId);

	always_comb begin
		if (bypass1) begin
			readData1 = writeData;
		end else begin
			readData1 = regs[readId1];
		end
	end

	always_comb begin
		if (bypass2) begin
			readData2 = writeData;
		end else begin
			readData2 = regs[readId2];
		end
	end

endmodule

/* hdl/aluUnit.sv */
module aluUnit (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         accept,
	input  logic                         latchResult,
	input  logic [execPkg::OpWidth-1:0]   op,
	input  logic [execPkg::DataWidth-1:0] operandA,
	input  logic [execPkg::DataWidth-1:0] operandB,
	input  logic [execPkg::DataWidth-1:0] imm,
	input  logic [execPkg::DataWidth-1:0] product,
	output logic [execPkg::DataWidth-1:0] resultData
);
	import execPkg::*;

	logic [OpWidth-1:0] opHeld;
	logic [DataWidth-1:0] aHeld;
	logic [DataWidth-1:0] bHeld;
	logic [DataWidth-1:0] immHeld;
	logic [DataWidth-1:0] aluNext;

	// operands are captured in the accept cycle, straight off the read ports.
	always_ff @(posedge clk) begin
		if (rst) begin
			opHeld <= '0;
			aHeld <= '0;
			bHeld <= '0;
			immHeld <= '0;
		end else if (accept) begin
			opHeld <= op;
			aHeld <= operandA;
			bHeld <= operandB;
			immHeld <= imm;
		end
	end

	always_comb begin
		case (opHeld)
			OpAdd: aluNext = aHeld + bHeld;
			OpSub: aluNext = aHeld - bHeld; // wraps.
			OpAnd: aluNext = aHeld & bHeld;
			OpOr: aluNext = aHeld | bHeld;
			OpXor: aluNext = aHeld ^ bHeld;
			OpLdi: aluNext = immHeld;
			OpMul: aluNext = product;
			default: aluNext = '0;
		endcase
	end

	// held through write-back and until the next instruction's EXEC.
	always_ff @(posedge clk) begin
		if (rst) begin
			resultData <= '0;
		end else if (latchResult) begin
			resultData <= aluNext;
		end
	end

endmodule

/* hdl/shiftAddMul.sv */
module shiftAddMul (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         accept,
	input  logic                         mulStep,
	input  logic [execPkg::DataWidth-1:0] multiplicand,
	input  logic [execPkg::DataWidth-1:0] multiplier,
	output logic [execPkg::DataWidth-1:0] product
);
	import execPkg::*;

	logic [DataWidth-1:0] mcand;
	logic [DataWidth-1:0] mplier;
	logic [DataWidth-1:0] partial;

	// bits shifted out of mcand only affect the upper half, which is dropped.
	always_ff @(posedge clk) begin
		if (rst) begin
			mcand <= '0;
			mplier <= '0;
			partial <= '0;
		end else if (accept) begin
			mcand <= multiplicand;
			mplier <= multiplier;
			partial <= '0;
		end else if (mulStep) begin
			if (mplier[0]) begin
				partial <= partial + mcand;
			end
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign product = partial; // final after MulSteps steps.

endmodule

/* hdl/stepCounter.sv */
module stepCounter (
	input  logic clk,
	input  logic rst,
	input  logic accept,
	input  logic mulStep,
	output logic lastStep
);
	import execPkg::*;

	logic [StepWidth-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (accept) begin
			count <= '0;
		end else if (mulStep) begin
			count <= count + 1'b1;
		end
	end

	// high during the final step cycle.
	assign lastStep = (count == StepWidth'(MulSteps - 1));

endmodule

/* hdl/execControl.sv */
module execControl (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start,
	input  logic [execPkg::OpWidth-1:0]    op,
	input  logic [execPkg::RegIdWidth-1:0] dstReg,
	input  logic                          lastStep,
	output logic                          accept,
	output logic                          mulStep,
	output logic                          latchResult,
	output logic                          writeEnable,
	output logic [execPkg::RegIdWidth-1:0] dstId,
	output logic                          busy,
	output logic                          done
);
	import execPkg::*;

	typedef enum logic [1:0] {
		StateIdle,
		StateMul,
		StateExec,
		StateWrite
	} stateT;

	stateT state;
	stateT stateNext;

	// ======================================================================
	// state register and destination
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= StateIdle;
			dstId <= '0;
		end else begin
			state <= stateNext;
			if (accept) begin
				dstId <= dstReg; // old dstId is still used by this edge's write.
			end
		end
	end

	// ======================================================================
	// next state
	// ======================================================================

	always_comb begin
		stateNext = state;
		case (state)
			StateIdle, StateWrite: begin
				// a start during WRITE overlaps the new read with write-back.
				if (start) begin
					stateNext = (op == OpMul) ? StateMul : StateExec;
				end else begin
					stateNext = StateIdle;
				end
			end
			StateMul: begin
				if (lastStep) begin
					stateNext = StateExec;
				end
			end
			StateExec: stateNext = StateWrite;
			default: stateNext = StateIdle;
		endcase
	end

	// strobes and status.
	assign accept = start && ((state == StateIdle) || (state == StateWrite));
	assign mulStep = (state == StateMul);
	assign latchResult = (state == StateExec);
	assign writeEnable = (state == StateWrite);
	assign done = (state == StateWrite);
	assign busy = (state == StateMul) || (state == StateExec);

endmodule

/* hdl/execUnit.sv */
module execUnit (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start,
	input  logic [execPkg::OpWidth-1:0]    op,
	input  logic [execPkg::RegIdWidth-1:0] dstReg,
	input  logic [execPkg::RegIdWidth-1:0] srcReg1,
	input  logic [execPkg::RegIdWidth-1:0] srcReg2,
	input  logic [execPkg::DataWidth-1:0]  imm,
	output logic                          busy,
	output logic                          done,
	output logic [execPkg::DataWidth-1:0]  result
);
	import execPkg::*;

	logic accept;
	logic mulStep;
	logic latchResult;
	logic writeEnable;
	logic lastStep;
	logic [RegIdWidth-1:0] dstId;
	logic [DataWidth-1:0] readData1;
	logic [DataWidth-1:0] readData2;
	logic [DataWidth-1:0] resultData;
	logic [DataWidth-1:0] product;

	// ======================================================================
	// control
	// ======================================================================

	execControl execControl_i (
		.clk(clk), .rst(rst), .start(start), .op(op), .dstReg(dstReg),
		.lastStep(lastStep), .accept(accept), .mulStep(mulStep),
		.latchResult(latchResult), .writeEnable(writeEnable), .dstId(dstId),
		.busy(busy), .done(done)
	);

	stepCounter stepCounter_i (
		.clk(clk), .rst(rst), .accept(accept), .mulStep(mulStep),
		.lastStep(lastStep)
	);

	// ======================================================================
	// datapath
	// ======================================================================

	// sources are addressed directly since they are read in the accept cycle.
	regFile regFile_i (
		.clk(clk), .rst(rst), .readId1(srcReg1), .readId2(srcReg2),
		.writeId(dstId), .writeEnable(writeEnable), .writeData(resultData),
		.readData1(readData1), .readData2(readData2)
	);

	aluUnit aluUnit_i (
		.clk(clk), .rst(rst), .accept(accept), .latchResult(latchResult),
		.op(op), .operandA(readData1), .operandB(readData2), .imm(imm),
		.product(product), .resultData(resultData)
	);

	shiftAddMul shiftAddMul_i (
		.clk(clk), .rst(rst), .accept(accept), .mulStep(mulStep),
		.multiplicand(readData1), .multiplier(readData2), .product(product)
	);

	assign result = resultData; // valid while done is high.

endmodule

/* tb/execModel.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// ======================================================================
// stimulus source and reference model
// ======================================================================

// fibonacci lfsr, taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// value an instruction writes back, from the operation table.
function automatic logic [DataWidth-1:0] expectedResult(
	input logic [OpWidth-1:0]   opCode,
	input logic [DataWidth-1:0] a,
	input logic [DataWidth-1:0] b,
	input logic [DataWidth-1:0] immVal
);
	logic [2*DataWidth-1:0] fullProduct;
	fullProduct = {{DataWidth{1'b0}}, a} * {{DataWidth{1'b0}}, b};
	case (opCode)
		OpAdd: return a + b;
		OpSub: return a - b; // modulo 2^16.
		OpAnd: return a & b;
		OpOr: return a | b;
		OpXor: return a ^ b;
		OpLdi: return immVal;
		OpMul: return fullProduct[DataWidth-1:0]; // low half only.
		default: return '0;
	endcase
endfunction

`endif

/* tb/execUnitTb.sv */
module execUnitTb;
	import execPkg::*;

	`include "execModel.svh"

	localparam int AluLatency = 2;
	localparam int MulLatency = MulSteps + 2; // sixteen steps, EXEC, WRITE.
	localparam int BusyTimeout = 40;
	localparam int DrainTimeout = 60;
	localparam int RandomCount = 300;

	logic clk;
	logic rst;
	logic start;
	logic [OpWidth-1:0] op;
	logic [RegIdWidth-1:0] dstReg;
	logic [RegIdWidth-1:0] srcReg1;
	logic [RegIdWidth-1:0] srcReg2;
	logic [DataWidth-1:0] imm;
	logic busy;
	logic done;
	logic [DataWidth-1:0] result;

	logic [DataWidth-1:0] modelRegs [RegCount];
	logic [DataWidth-1:0] expValues [$];
	int expCycles [$];
	logic [31:0] lfsrState;
	int cycleCount = 0;
	int valueErrors = 0;
	int timingErrors = 0;
	int protocolErrors = 0;
	bit aborted = 0;

	execUnit execUnit_i (
		.clk(clk), .rst(rst), .start(start), .op(op), .dstReg(dstReg),
		.srcReg1(srcReg1), .srcReg2(srcReg2), .imm(imm), .busy(busy),
		.done(done), .result(result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycleCount <= cycleCount + 1;

	// one lfsr step per bit taken.
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return bits;
	endfunction

	task automatic idleCycles(input int count);
		repeat (count) begin
			@(posedge clk);
			#1;
		end
	endtask

	// ======================================================================
	// issue and compare
	// ======================================================================

	task automatic issueInstr(
		input logic [OpWidth-1:0]    opIn,
		input logic [RegIdWidth-1:0] dst,
		input logic [RegIdWidth-1:0] src1,
		input logic [RegIdWidth-1:0] src2,
		input logic [DataWidth-1:0]  immIn
	);
		int waited;
		logic [DataWidth-1:0] expVal;
		if (aborted) return;
		waited = 0;
		while (busy !== 1'b0 && waited < BusyTimeout) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (busy !== 1'b0) begin
			$display("busy stayed high for %0d cycles at time %0t", BusyTimeout, $time);
			protocolErrors++;
			aborted = 1;
			return;
		end
		start = 1'b1;
		op = opIn;
		dstReg = dst;
		srcReg1 = src1;
		srcReg2 = src2;
		imm = immIn;
		expVal = expectedResult(opIn, modelRegs[src1], modelRegs[src2], immIn);
		modelRegs[dst] = expVal;
		expValues.push_back(expVal);
		expCycles.push_back(cycleCount + ((opIn == OpMul) ? MulLatency : AluLatency));
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	// a start that lands while busy must leave no trace.
	task automatic pokeWhileBusy(
		input logic [OpWidth-1:0]    opIn,
		input logic [RegIdWidth-1:0] dst,
		input logic [DataWidth-1:0]  immIn
	);
		if (aborted) return;
		if (busy !== 1'b1) begin
			$display("start to be ignored found the unit idle at time %0t", $time);
			protocolErrors++;
		end else begin
			start = 1'b1;
			op = opIn;
			dstReg = dst;
			srcReg1 = dst;
			srcReg2 = ~dst;
			imm = immIn;
			@(posedge clk);
			#1;
			start = 1'b0;
		end
	endtask

	task automatic drainQueue();
		int waited;
		waited = 0;
		while (expValues.size() != 0 && waited < DrainTimeout) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (expValues.size() != 0) begin
			$display("%0d results never arrived", expValues.size());
			protocolErrors++;
		end
	endtask

	always @(negedge clk) begin
		if (done === 1'b1) begin
			if (busy !== 1'b0) begin
				$display("FAILED at time %0t: busy high in the write-back cycle", $time);
				protocolErrors++;
			end
			if (expValues.size() == 0) begin
				$display("done with no instruction outstanding at time %0t", $time);
				protocolErrors++;
			end else begin
				if (cycleCount != expCycles[0]) begin
					$display("FAILED at time %0t: done in cycle %0d, expected cycle %0d",
						$time, cycleCount, expCycles[0]);
					timingErrors++;
				end
				if (result !== expValues[0]) begin
					$display("FAILED at time %0t: result %h, expected %h",
						$time, result, expValues[0]);
					valueErrors++;
				end
				void'(expValues.pop_front());
				void'(expCycles.pop_front());
			end
		end else if (expValues.size() != 0 && cycleCount >= expCycles[0]) begin
			$display("done missing in cycle %0d at time %0t", expCycles[0], $time);
			protocolErrors++;
			void'(expValues.pop_front());
			void'(expCycles.pop_front());
		end
	end

	task automatic finishRun();
		$display("errors: value %0d, timing %0d, protocol %0d",
			valueErrors, timingErrors, protocolErrors);
		if (valueErrors + timingErrors + protocolErrors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================

	initial begin
		logic [OpWidth-1:0] rOp;
		logic [RegIdWidth-1:0] rDst;
		logic [RegIdWidth-1:0] rSrc1;
		logic [RegIdWidth-1:0] rSrc2;
		logic [DataWidth-1:0] rImm;
		rst = 1'b1;
		start = 1'b0;
		op = '0;
		dstReg = '0;
		srcReg1 = '0;
		srcReg2 = '0;
		imm = '0;
		lfsrState = 32'h5328_a96f;
		for (int r = 0; r < RegCount; r++) begin
			modelRegs[r] = '0;
		end
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		if (busy !== 1'b0 || done !== 1'b0) begin
			$display("busy or done not low after reset at time %0t", $time);
			protocolErrors++;
		end
		issueInstr(OpAdd, 4'd1, 4'd2, 4'd3, 16'h0000); // registers start at zero.
		idleCycles(3);
		issueInstr(OpLdi, 4'd1, 4'd0, 4'd0, 16'h1234);
		issueInstr(OpLdi, 4'd2, 4'd0, 4'd0, 16'h00ff);
		idleCycles(2);
		issueInstr(OpLdi, 4'd3, 4'd0, 4'd0, 16'hf00f);
		issueInstr(OpAdd, 4'd4, 4'd1, 4'd2, 16'h0000);
		issueInstr(OpSub, 4'd5, 4'd2, 4'd1, 16'h0000); // borrows through.
		issueInstr(OpAnd, 4'd6, 4'd1, 4'd3, 16'h0000);
		issueInstr(OpOr, 4'd7, 4'd2, 4'd3, 16'h0000);
		issueInstr(OpXor, 4'd8, 4'd1, 4'd3, 16'h0000);
		issueInstr(OpMul, 4'd7, 4'd1, 4'd2, 16'h0000);
		issueInstr(OpMul, 4'd9, 4'd7, 4'd3, 16'h0000); // multiplicand via bypass.
		issueInstr(OpMul, 4'd8, 4'd3, 4'd3, 16'h0000);
		issueInstr(OpLdi, 4'd10, 4'd0, 4'd0, 16'h0005);
		issueInstr(OpAdd, 4'd10, 4'd10, 4'd10, 16'h0000);
		issueInstr(OpSub, 4'd11, 4'd10, 4'd1, 16'h0000);
		issueInstr(OpXor, 4'd10, 4'd11, 4'd10, 16'h0000);
		issueInstr(OpLdi, 4'd0, 4'd0, 4'd0, 16'h8001);
		issueInstr(OpAdd, 4'd0, 4'd0, 4'd0, 16'h0000); // r0 is a normal register.
		issueInstr(OpMul, 4'd12, 4'd1, 4'd2, 16'h0000);
		pokeWhileBusy(OpLdi, 4'd12, 16'hdead);
		pokeWhileBusy(OpAdd, 4'd1, 16'hbeef);
		idleCycles(5);
		pokeWhileBusy(OpLdi, 4'd2, 16'h5a5a);
		issueInstr(OpAdd, 4'd13, 4'd12, 4'd1, 16'h0000);
		pokeWhileBusy(OpLdi, 4'd13, 16'hffff); // lands in EXEC.
		drainQueue();
		for (int n = 0; n < RandomCount; n++) begin
			rOp = OpWidth'(takeBits(OpWidth));
			rDst = RegIdWidth'(takeBits(2)); // r0..r3 keeps dependencies dense.
			rSrc1 = RegIdWidth'(takeBits(2));
			rSrc2 = RegIdWidth'(takeBits(2));
			rImm = DataWidth'(takeBits(DataWidth));
			issueInstr(rOp, rDst, rSrc1, rSrc2, rImm);
			if (takeBits(2) == 0) begin
				pokeWhileBusy(OpWidth'(takeBits(OpWidth)), RegIdWidth'(takeBits(2)),
					DataWidth'(takeBits(DataWidth)));
			end
			if (takeBits(2) == 0) begin
				idleCycles(1 + takeBits(2));
			end
		end
		drainQueue();
		finishRun();
	end

endmodule

/* tb.f */
+incdir+tb
hdl/execPkg.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/shiftAddMul.sv
hdl/stepCounter.sv
hdl/execControl.sv
hdl/execUnit.sv
tb/execUnitTb.sv
